// File: verilog/compliance_params.svh
// Compliance harness constants
// Bus widths, RAM size, device address windows and test utility register map

`ifndef COMPLIANCE_PARAMS_SVH
`define COMPLIANCE_PARAMS_SVH

// Bus widths
`define ADDR_W 32
`define DATA_W 32

// RAM size in 32-bit words
`define RAM_DEPTH 1024

// Device windows, a hit is (addr & mask) == base
`define RAM_BASE 32'h0000_0000
`define RAM_MASK 32'hFFFF_F000
`define TU_BASE  32'h0002_0000
`define TU_MASK  32'hFFFF_FC00

// Test utility register offsets within its window
`define TU_SIG_BEGIN 32'h0000_0000
`define TU_SIG_END   32'h0000_0004
`define TU_HALT      32'h0000_0008

`endif

// File: verilog/compliance_pkg.sv
// Compliance harness bus types
// Request and response words plus the host and device slot names

package compliance_pkg;

  localparam int NrHosts   = 3;
  localparam int NrDevices = 2;

  // Request word, sent next to a separate req strobe
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } bus_req_t;

  // Response word, sent next to a separate rvalid strobe
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } bus_rsp_t;

  // Host slots, highest priority first
  typedef enum logic [1:0] {
    TestUtilHost,
    CoreD,
    CoreI
  } bus_host_e;

  typedef enum logic [0:0] {
    Ram,
    TestUtil
  } bus_device_e;

endpackage

// File: verilog/bus_interconnect.sv
// Shared request/grant bus
// Fixed-priority arbiter, base/mask address decode and one-cycle response return
`timescale 1ns/1ps
`include "compliance_params.svh"

module bus_interconnect import compliance_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,

  input  logic     host_req_i    [NrHosts],
  input  bus_req_t host_bus_i    [NrHosts],
  output logic     host_gnt_o    [NrHosts],
  output logic     host_rvalid_o [NrHosts],
  output bus_rsp_t host_rsp_o    [NrHosts],

  output logic     dev_req_o     [NrDevices],
  output bus_req_t dev_bus_o     [NrDevices],
  input  logic     dev_rvalid_i  [NrDevices],
  input  bus_rsp_t dev_rsp_i     [NrDevices]
);

  logic                 any_req;
  bus_host_e            host_sel;
  bus_req_t             sel_bus;
  logic [NrDevices-1:0] dev_hit;
  bus_device_e          dev_sel;
  logic [NrHosts-1:0]   gnt_vec;

  logic                 rsp_valid_q;
  logic                 rsp_unmapped_q;
  bus_host_e            rsp_host_q;
  bus_device_e          rsp_dev_q;
  logic                 rsp_fire;
  bus_rsp_t             rsp_word;

  // Lowest index wins, each request is masked by any earlier one
  always_comb begin
    any_req  = 1'b0;
    host_sel = TestUtilHost;
    for (int i = 0; i < NrHosts; i++) begin
      gnt_vec[i] = host_req_i[i] && !any_req;
      if (gnt_vec[i]) begin
        host_sel = bus_host_e'(i);
      end
      any_req = any_req || host_req_i[i];
    end
  end

  assign sel_bus = host_bus_i[host_sel];

  // Address decode
  assign dev_hit[Ram]      = (sel_bus.addr & `RAM_MASK) == `RAM_BASE;
  assign dev_hit[TestUtil] = (sel_bus.addr & `TU_MASK) == `TU_BASE;
  assign dev_sel           = dev_hit[TestUtil] ? TestUtil : Ram;

  always_comb begin
    for (int i = 0; i < NrHosts; i++) begin
      host_gnt_o[i] = gnt_vec[i];
    end
  end

  // Every device sees the bus word, only the decoded one gets req
  always_comb begin
    for (int d = 0; d < NrDevices; d++) begin
      dev_req_o[d] = any_req && dev_hit[d];
      dev_bus_o[d] = sel_bus;
    end
  end

  // Remember who was granted so the response can be routed back
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_valid_q    <= 1'b0;
      rsp_unmapped_q <= 1'b0;
      rsp_host_q     <= TestUtilHost;
      rsp_dev_q      <= Ram;
    end else begin
      rsp_valid_q    <= any_req;
      rsp_unmapped_q <= any_req && !(|dev_hit);
      if (any_req) begin
        rsp_host_q <= host_sel;
        rsp_dev_q  <= dev_sel;
      end
    end
  end

  // Unmapped accesses answer themselves with err
  assign rsp_fire = rsp_valid_q && (rsp_unmapped_q || dev_rvalid_i[rsp_dev_q]);
  assign rsp_word = rsp_unmapped_q ? bus_rsp_t'{rdata: '0, err: 1'b1} : dev_rsp_i[rsp_dev_q];

  always_comb begin
    for (int i = 0; i < NrHosts; i++) begin
      host_rvalid_o[i] = rsp_fire && (rsp_host_q == bus_host_e'(i));
      host_rsp_o[i]    = rsp_word;
    end
  end

  gnt_onehot_a: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(gnt_vec));

  // Devices must answer exactly one cycle after their req
  for (genvar d = 0; d < NrDevices; d++) begin : g_dev_chk
    dev_rvalid_after_req_a: assert property (@(posedge clk_i) disable iff (reset_i)
      dev_rvalid_i[d] |-> $past(dev_req_o[d]));
  end

endmodule

// File: verilog/ram_1p.sv
// Single-port word RAM
// Byte-enable writes, every access answers one cycle later with the old word
`timescale 1ns/1ps
`include "compliance_params.svh"

module ram_1p import compliance_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     req_i,
  input  bus_req_t bus_i,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  localparam int IdxW = $clog2(`RAM_DEPTH);

  logic [`DATA_W-1:0] mem [`RAM_DEPTH];
  logic [`ADDR_W-1:0] win_off;
  logic [IdxW-1:0]    word_idx;
  logic [`DATA_W-1:0] rdata_q;
  logic               rvalid_q;

  // Offset within the RAM window, byte address to word index
  assign win_off  = bus_i.addr - `RAM_BASE;
  assign word_idx = win_off[IdxW+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= mem[word_idx];
      if (bus_i.we) begin
        for (int b = 0; b < `DATA_W / 8; b++) begin
          if (bus_i.be[b]) begin
            mem[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = '{rdata: rdata_q, err: 1'b0};

  // Window size and depth have to agree, else words alias
  idx_in_depth_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_i |-> (win_off[`ADDR_W-1:2] < `RAM_DEPTH));

endmodule

// File: verilog/riscv_testutil.sv
// RISC-V test utility
// Signature registers on the device port, and a host that dumps the signature
`timescale 1ns/1ps
`include "compliance_params.svh"

module riscv_testutil import compliance_pkg::*; (
  input  logic              clk_i,
  input  logic              reset_i,

  input  logic              dev_req_i,
  input  bus_req_t          dev_bus_i,
  output logic              dev_rvalid_o,
  output bus_rsp_t          dev_rsp_o,

  output logic              host_req_o,
  output bus_req_t          host_bus_o,
  input  logic              host_gnt_i,
  input  logic              host_rvalid_i,
  input  bus_rsp_t          host_rsp_i,

  output logic              sig_valid_o,
  output logic [`DATA_W-1:0] sig_word_o,
  output logic              halted_o
);

  typedef enum logic [1:0] {
    StIdle,
    StDump,
    StHalted
  } tu_state_e;

  localparam logic [`ADDR_W-1:0] WordStep = 4;

  logic [`ADDR_W-1:0] tu_off;
  logic [`ADDR_W-1:0] sig_begin_q;
  logic [`ADDR_W-1:0] sig_end_q;
  logic [`DATA_W-1:0] reg_rdata;
  logic               reg_err;
  logic               halt_wr;
  logic               dev_rvalid_q;
  logic [`DATA_W-1:0] dev_rdata_q;
  logic               dev_err_q;

  tu_state_e          state_q;
  logic [`ADDR_W-1:0] addr_q;
  logic [1:0]         outstanding_q;
  logic               addr_live;
  logic               dump_done;
  logic               sig_valid_q;
  logic [`DATA_W-1:0] sig_word_q;

  assign tu_off  = dev_bus_i.addr & ~`TU_MASK;
  assign halt_wr = dev_req_i && dev_bus_i.we && (tu_off == `TU_HALT);

  // Register readback, halt reads as zero
  always_comb begin
    reg_rdata = '0;
    reg_err   = 1'b0;
    case (tu_off)
      `TU_SIG_BEGIN: reg_rdata = sig_begin_q;
      `TU_SIG_END:   reg_rdata = sig_end_q;
      `TU_HALT:      reg_rdata = '0;
      default:       reg_err   = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      dev_rvalid_q <= 1'b0;
      sig_begin_q  <= '0;
      sig_end_q    <= '0;
    end else begin
      dev_rvalid_q <= dev_req_i;
      if (dev_req_i && dev_bus_i.we && tu_off == `TU_SIG_BEGIN) begin
        sig_begin_q <= dev_bus_i.wdata;
      end
      if (dev_req_i && dev_bus_i.we && tu_off == `TU_SIG_END) begin
        sig_end_q <= dev_bus_i.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev_req_i) begin
      dev_rdata_q <= reg_rdata;
      dev_err_q   <= reg_err;
    end
  end

  assign dev_rvalid_o = dev_rvalid_q;
  assign dev_rsp_o    = '{rdata: dev_rdata_q, err: dev_err_q};

  // Dump sequencer
  assign addr_live = addr_q < sig_end_q;
  assign dump_done = !addr_live && (outstanding_q == 2'd0);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q       <= StIdle;
      addr_q        <= '0;
      outstanding_q <= 2'd0;
      sig_valid_q   <= 1'b0;
    end else begin
      sig_valid_q <= host_rvalid_i;
      case ({host_req_o && host_gnt_i, host_rvalid_i})
        2'b10:   outstanding_q <= outstanding_q + 2'd1;
        2'b01:   outstanding_q <= outstanding_q - 2'd1;
        default: outstanding_q <= outstanding_q;
      endcase
      case (state_q)
        StIdle: begin
          if (halt_wr) begin
            state_q <= StDump;
            addr_q  <= {sig_begin_q[`ADDR_W-1:2], 2'b00};
          end
        end
        StDump: begin
          if (host_req_o && host_gnt_i) begin
            addr_q <= addr_q + WordStep;
          end
          if (dump_done) begin
            state_q <= StHalted;
          end
        end
        // Halted until reset
        default: state_q <= state_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (host_rvalid_i) begin
      sig_word_q <= host_rsp_i.rdata;
    end
  end

  assign host_req_o  = (state_q == StDump) && addr_live;
  assign host_bus_o  = '{addr: addr_q, we: 1'b0, be: 4'hF, wdata: '0};
  assign sig_valid_o = sig_valid_q;
  assign sig_word_o  = sig_word_q;
  assign halted_o    = (state_q == StHalted);

  // Request has to wait for the bus grant unchanged
  host_req_held_a: assert property (@(posedge clk_i) disable iff (reset_i)
    host_req_o && !host_gnt_i |=> host_req_o && $stable(host_bus_o.addr));

endmodule

// File: verilog/compliance_top.sv
// Compliance harness top level
// Bus with RAM and test utility, the core data and instruction ports as inputs
`timescale 1ns/1ps

module compliance_top import compliance_pkg::*; (
  input  logic        clk_i,
  input  logic        reset_i,

  input  logic        core_d_req_i,
  input  bus_req_t    core_d_bus_i,
  output logic        core_d_gnt_o,
  output logic        core_d_rvalid_o,
  output bus_rsp_t    core_d_rsp_o,

  input  logic        core_i_req_i,
  input  bus_req_t    core_i_bus_i,
  output logic        core_i_gnt_o,
  output logic        core_i_rvalid_o,
  output bus_rsp_t    core_i_rsp_o,

  output logic        sig_valid_o,
  output logic [31:0] sig_word_o,
  output logic        halted_o
);

  logic     host_req    [NrHosts];
  bus_req_t host_bus    [NrHosts];
  logic     host_gnt    [NrHosts];
  logic     host_rvalid [NrHosts];
  bus_rsp_t host_rsp    [NrHosts];

  logic     dev_req     [NrDevices];
  bus_req_t dev_bus     [NrDevices];
  logic     dev_rvalid  [NrDevices];
  bus_rsp_t dev_rsp     [NrDevices];

  // External host slots
  assign host_req[CoreD]  = core_d_req_i;
  assign host_bus[CoreD]  = core_d_bus_i;
  assign core_d_gnt_o     = host_gnt[CoreD];
  assign core_d_rvalid_o  = host_rvalid[CoreD];
  assign core_d_rsp_o     = host_rsp[CoreD];

  assign host_req[CoreI]  = core_i_req_i;
  assign host_bus[CoreI]  = core_i_bus_i;
  assign core_i_gnt_o     = host_gnt[CoreI];
  assign core_i_rvalid_o  = host_rvalid[CoreI];
  assign core_i_rsp_o     = host_rsp[CoreI];

  bus_interconnect u_bus (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .host_req_i    (host_req),
    .host_bus_i    (host_bus),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rsp_o    (host_rsp),
    .dev_req_o     (dev_req),
    .dev_bus_o     (dev_bus),
    .dev_rvalid_i  (dev_rvalid),
    .dev_rsp_i     (dev_rsp)
  );

  ram_1p u_ram (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (dev_req[Ram]),
    .bus_i    (dev_bus[Ram]),
    .rvalid_o (dev_rvalid[Ram]),
    .rsp_o    (dev_rsp[Ram])
  );

  riscv_testutil u_riscv_testutil (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .dev_req_i     (dev_req[TestUtil]),
    .dev_bus_i     (dev_bus[TestUtil]),
    .dev_rvalid_o  (dev_rvalid[TestUtil]),
    .dev_rsp_o     (dev_rsp[TestUtil]),
    .host_req_o    (host_req[TestUtilHost]),
    .host_bus_o    (host_bus[TestUtilHost]),
    .host_gnt_i    (host_gnt[TestUtilHost]),
    .host_rvalid_i (host_rvalid[TestUtilHost]),
    .host_rsp_i    (host_rsp[TestUtilHost]),
    .sig_valid_o   (sig_valid_o),
    .sig_word_o    (sig_word_o),
    .halted_o      (halted_o)
  );

endmodule

// File: verif/compliance_tb.sv
// Compliance harness testbench
// Drives the core data and instruction ports, concurrent assertions check the bus
`timescale 1ns/1ps
`include "compliance_params.svh"

module compliance_tb import compliance_pkg::*; ();

  // Whole run needs a few hundred cycles, so this leaves a wide margin
  localparam int MaxCycles = 3000;

  logic        clk;
  logic        reset;
  logic        d_req, d_gnt, d_rvalid;
  logic        i_req, i_gnt, i_rvalid;
  bus_req_t    d_bus, i_bus;
  bus_rsp_t    d_rsp, i_rsp;
  logic        sig_valid;
  logic        halted;
  logic [31:0] sig_word;

  // Reference state built from the bus rules
  logic [31:0] model_mem [`RAM_DEPTH];
  logic [31:0] tu_begin_m, tu_end_m;
  bus_rsp_t    exp_d, exp_i;
  logic        chk_d, chk_i;
  logic        started;
  logic        d_gnt_q, i_gnt_q;
  logic        dump_busy;
  int          dump_left;
  logic [31:0] exp_sig_word;
  logic [31:0] exp_words;
  int          sig_cnt;
  int          cycles = 0;
  int          errors;
  int          errors_before;
  int          tests_run;
  integer      seed;

  compliance_top dut0 (
    .clk_i           (clk),
    .reset_i         (reset),
    .core_d_req_i    (d_req),
    .core_d_bus_i    (d_bus),
    .core_d_gnt_o    (d_gnt),
    .core_d_rvalid_o (d_rvalid),
    .core_d_rsp_o    (d_rsp),
    .core_i_req_i    (i_req),
    .core_i_bus_i    (i_bus),
    .core_i_gnt_o    (i_gnt),
    .core_i_rvalid_o (i_rvalid),
    .core_i_rsp_o    (i_rsp),
    .sig_valid_o     (sig_valid),
    .sig_word_o      (sig_word),
    .halted_o        (halted)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign exp_sig_word = model_mem[tu_begin_m[11:2] + sig_cnt[9:0]];
  assign exp_words    = (tu_end_m - tu_begin_m) >> 2;

  // Dump reads own the bus one cycle per word, starting the cycle after the halt write
  always @(posedge clk) begin
    if (reset) begin
      dump_left <= 0;
    end else if (d_req && d_gnt && d_bus.we && d_bus.addr == `TU_BASE + `TU_HALT) begin
      dump_left <= exp_words;
    end else if (dump_left != 0) begin
      dump_left <= dump_left - 1;
    end
  end

  assign dump_busy = (dump_left != 0);

  // Grants taken on the rising edge, read back by the tasks on the falling one
  always @(posedge clk) begin
    d_gnt_q <= d_gnt && !reset;
    i_gnt_q <= i_gnt && !reset;
    cycles  <= cycles + 1;
    if (reset) begin
      sig_cnt <= 0;
    end else if (sig_valid) begin
      sig_cnt <= sig_cnt + 1;
    end
    if (cycles >= MaxCycles) begin
      $display("Timeout: the run was still busy after %0d cycles", MaxCycles);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic flag_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic report_test(input string name);
    tests_run++;
    $display("test %0d %s: %s", tests_run, name, (errors == errors_before) ? "ok" : "not ok");
    errors_before = errors;
  endtask

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w, input logic [3:0] be);
    logic [31:0] merged;
    merged = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        merged[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // One access on the data port, or the instruction port when use_i is set
  task automatic bus_access(input logic use_i, input logic [31:0] addr, input logic we,
                            input logic [3:0] be, input logic [31:0] wdata);
    bus_req_t req;
    bus_rsp_t want;
    req     = '{addr: addr, we: we, be: be, wdata: wdata};
    want    = '{rdata: '0, err: 1'b0};
    started = 1'b1;
    if (use_i) begin
      i_req = 1'b1;
      i_bus = req;
    end else begin
      d_req = 1'b1;
      d_bus = req;
    end
    @(negedge clk);
    while (!(use_i ? i_gnt_q : d_gnt_q)) begin
      @(negedge clk);
    end
    // Granted on the last edge, the response is due on the next one
    if ((addr & `RAM_MASK) == `RAM_BASE) begin
      want.rdata = model_mem[addr[11:2]];
      if (we) begin
        model_mem[addr[11:2]] = merge_bytes(model_mem[addr[11:2]], wdata, be);
      end
    end else if ((addr & `TU_MASK) == `TU_BASE) begin
      case (addr & ~`TU_MASK)
        `TU_SIG_BEGIN: want.rdata = tu_begin_m;
        `TU_SIG_END:   want.rdata = tu_end_m;
        `TU_HALT:      want.rdata = '0;
        default:       want.err   = 1'b1;
      endcase
      if (we && (addr & ~`TU_MASK) == `TU_SIG_BEGIN) begin
        tu_begin_m = wdata;
      end
      if (we && (addr & ~`TU_MASK) == `TU_SIG_END) begin
        tu_end_m = wdata;
      end
    end else begin
      want.err = 1'b1;
    end
    if (use_i) begin
      exp_i = want;
      chk_i = !we && !want.err;
      i_req = 1'b0;
    end else begin
      exp_d = want;
      chk_d = !we && !want.err;
      d_req = 1'b0;
    end
    while (!(use_i ? i_rvalid : d_rvalid)) begin
      @(negedge clk);
    end
  endtask

  reset_quiet_a: assert property (@(posedge clk) disable iff (reset)
    !started |-> !(d_gnt || i_gnt || d_rvalid || i_rvalid || sig_valid || halted))
    else flag_error("bus activity before the first request");
  d_rvalid_timing_a: assert property (@(posedge clk) disable iff (reset)
    d_rvalid == $past(d_gnt)) else flag_error("data port rvalid not one cycle after gnt");
  i_rvalid_timing_a: assert property (@(posedge clk) disable iff (reset)
    i_rvalid == $past(i_gnt)) else flag_error("instr port rvalid not one cycle after gnt");
  d_rsp_a: assert property (@(posedge clk) disable iff (reset)
    d_rvalid |-> d_rsp.err == exp_d.err && (!chk_d || d_rsp.rdata == exp_d.rdata))
    else flag_error("wrong response on the data port");
  i_rsp_a: assert property (@(posedge clk) disable iff (reset)
    i_rvalid |-> i_rsp.err == exp_i.err && (!chk_i || i_rsp.rdata == exp_i.rdata))
    else flag_error("wrong response on the instruction port");
  prio_a: assert property (@(posedge clk) disable iff (reset)
    d_req |-> !i_gnt) else flag_error("instruction port granted over the data port");
  prio_next_a: assert property (@(posedge clk) disable iff (reset)
    $fell(d_req) && i_req && !dump_busy |-> i_gnt)
    else flag_error("instruction port not granted once the data port let go");
  dump_refuse_a: assert property (@(posedge clk) disable iff (reset)
    dump_busy |-> !d_gnt && !i_gnt) else flag_error("external port granted during a dump read");
  sig_word_a: assert property (@(posedge clk) disable iff (reset)
    sig_valid |-> sig_word == exp_sig_word) else flag_error("wrong signature word");
  halt_count_a: assert property (@(posedge clk) disable iff (reset)
    $rose(halted) |-> sig_cnt == exp_words) else flag_error("halted after wrong word count");

  initial begin
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  be;
    reset         = 1'b1;
    d_req         = 1'b0;
    i_req         = 1'b0;
    d_bus         = '0;
    i_bus         = '0;
    exp_d         = '0;
    exp_i         = '0;
    chk_d         = 1'b0;
    chk_i         = 1'b0;
    started       = 1'b0;
    tu_begin_m    = '0;
    tu_end_m      = '0;
    errors        = 0;
    errors_before = 0;
    tests_run     = 0;
    seed          = 9;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (3) @(negedge clk);
    report_test("reset");

    // Full word first so every byte of the model is known
    for (int n = 0; n < 4; n++) begin
      addr = $random(seed) & 32'h0000_0FFC;
      data = $random(seed);
      be   = $random(seed);
      bus_access(1'b0, addr, 1'b1, 4'hF, ~data);
      bus_access(1'b0, addr, 1'b1, be, data);
      bus_access(1'b1, addr, 1'b0, 4'hF, '0);
    end
    report_test("ram write and read");

    fork
      bus_access(1'b0, 32'h0000_0200, 1'b1, 4'hF, 32'hCAFE_0001);
      bus_access(1'b1, 32'h0000_0200, 1'b0, 4'hF, '0);
    join
    report_test("priority");

    bus_access(1'b0, 32'h0004_0000, 1'b0, 4'hF, '0);
    bus_access(1'b1, `TU_BASE + 32'h10, 1'b0, 4'hF, '0);
    bus_access(1'b0, `TU_BASE + 32'h10, 1'b1, 4'hF, 32'h1);
    report_test("errors");

    bus_access(1'b0, `TU_BASE + `TU_SIG_BEGIN, 1'b1, 4'hF, 32'h1234_5670);
    bus_access(1'b0, `TU_BASE + `TU_SIG_END, 1'b1, 4'hF, 32'h0000_0ABC);
    bus_access(1'b1, `TU_BASE + `TU_SIG_BEGIN, 1'b0, 4'hF, '0);
    bus_access(1'b1, `TU_BASE + `TU_SIG_END, 1'b0, 4'hF, '0);
    bus_access(1'b1, `TU_BASE + `TU_HALT, 1'b0, 4'hF, '0);
    report_test("test utility registers");

    for (int n = 0; n < 8; n++) begin
      bus_access(1'b0, 32'h0000_0100 + 4 * n, 1'b1, 4'hF, $random(seed));
    end
    bus_access(1'b0, `TU_BASE + `TU_SIG_BEGIN, 1'b1, 4'hF, 32'h0000_0100);
    bus_access(1'b0, `TU_BASE + `TU_SIG_END, 1'b1, 4'hF, 32'h0000_0120);
    bus_access(1'b0, `TU_BASE + `TU_HALT, 1'b1, 4'hF, 32'h1);
    // Issued while the dump reads hold the bus
    bus_access(1'b1, 32'h0000_0104, 1'b0, 4'hF, '0);
    while (!halted) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk);
    report_test("signature dump");

    $display("%0d tests run, %0d checks failed", tests_run, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+verilog
verilog/compliance_pkg.sv
verilog/bus_interconnect.sv
verilog/ram_1p.sv
verilog/riscv_testutil.sv
verilog/compliance_top.sv
verif/compliance_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and check the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module compliance_tb -f vlog.f -Mdir obj_dir \
  || { echo "Build failed"; exit 1; }
./obj_dir/Vcompliance_tb | tee /dev/stderr | grep -q "All tests passed" \
  && echo "Simulation result: PASS" \
  || { echo "Simulation result: FAIL"; exit 1; }
